// File: hw/chol_pkg.sv
package chol_pkg;

    // ========================================================================
    // Matrix geometry and fixed-point format
    // ========================================================================

    localparam int N_DIM     = 5;                      // Rows and columns of A
    localparam int N_ELEM    = N_DIM * (N_DIM + 1) / 2; // Lower triangle incl. diagonal
    localparam int FRAC_BITS = 16;                     // Q16.16

    typedef logic signed [31:0] fix_t;    // One matrix element
    typedef logic signed [63:0] prod_t;   // Product or running sum
    typedef logic        [23:0] root_t;   // Raw root before zero extension
    typedef logic [N_ELEM*$bits(fix_t)-1:0] mat_t; // Packed row by row, a11 in the low word
    typedef logic        [2:0]  idx_t;    // Row, column or k index

    // ========================================================================
    // Sequencer states
    // ========================================================================

    typedef enum logic [2:0] {
        S_IDLE,   // No matrix held
        S_LOAD,   // Buffer to working store, credit back
        S_DOT,    // Dot product and subtract
        S_ROOT,   // Diagonal element
        S_DIV,    // Element below the diagonal
        S_DONE    // Result valid
    } seq_state_t;

endpackage

// File: hw/chol_isqrt.sv
`timescale 1ns/100ps

module chol_isqrt #(
    parameter int ROOT_ITERS = 24
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  chol_pkg::fix_t radicand,
    output logic          done,
    output chol_pkg::fix_t root
);

    localparam int XW = $bits(chol_pkg::fix_t) + chol_pkg::FRAC_BITS; // Radicand << 16
    localparam int RW = $bits(chol_pkg::root_t) + 4;                   // Signed partial remainder
    localparam int CW = $clog2(ROOT_ITERS + 1);

    logic [XW-1:0]        x;       // Radicand bits, two per step from the top
    logic signed [RW-1:0] rem;
    logic signed [RW-1:0] rem_sh;
    logic signed [RW-1:0] rem_nx;
    logic [RW-1:0]        trial;
    chol_pkg::root_t      q;
    logic [CW-1:0]        cnt;     // Steps left, zero when idle

    // Non-restoring step: subtract 4q+1 after a positive remainder,
    // add 4q+3 after a negative one
    assign rem_sh = {rem[RW-3:0], x[XW-1 -: 2]};
    assign trial  = {2'b00, q, rem[RW-1], 1'b1};
    assign rem_nx = rem[RW-1] ? rem_sh + trial : rem_sh - trial;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cnt <= CW'(ROOT_ITERS);
            end else if (cnt != '0) begin
                cnt  <= cnt - CW'(1);
                done <= (cnt == CW'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            x   <= {radicand, {chol_pkg::FRAC_BITS{1'b0}}};
            rem <= '0;
            q   <= '0;
        end else if (cnt != '0) begin
            x   <= {x[XW-3:0], 2'b00};
            rem <= rem_nx;
            q   <= {q[$bits(chol_pkg::root_t)-2:0], ~rem_nx[RW-1]}; // Root bit from new sign
        end
    end

    assign root = {{($bits(chol_pkg::fix_t) - $bits(chol_pkg::root_t)){1'b0}}, q};

    // A non-positive pivot means A was not positive definite
    a_pivot_positive: assert property (@(posedge clk) disable iff (rst)
        start |-> radicand > 0);

endmodule

// File: hw/chol_divider.sv
`timescale 1ns/100ps

module chol_divider #(
    parameter int DIV_ITERS = 48
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  chol_pkg::fix_t dividend,
    input  chol_pkg::fix_t divisor,
    output logic          done,
    output chol_pkg::fix_t quotient
);

    localparam int FW = $bits(chol_pkg::fix_t);
    localparam int NW = FW + chol_pkg::FRAC_BITS; // Dividend magnitude << 16
    localparam int CW = $clog2(DIV_ITERS + 1);

    logic [FW-1:0]  mag;
    logic [NW-1:0]  num;      // Dividend bits shift out, quotient bits shift in
    logic [FW:0]    rem;
    logic [FW:0]    rem_sh;
    logic [FW:0]    diff;
    chol_pkg::fix_t dvs;
    logic           neg;
    logic [CW-1:0]  cnt;      // Steps left, zero when idle

    assign mag    = dividend[FW-1] ? -dividend : dividend;
    assign rem_sh = {rem[FW-1:0], num[NW-1]};
    assign diff   = rem_sh - {1'b0, dvs};   // Bit FW set when the trial goes negative

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cnt <= CW'(DIV_ITERS);
            end else if (cnt != '0) begin
                cnt  <= cnt - CW'(1);
                done <= (cnt == CW'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            num <= {mag, {chol_pkg::FRAC_BITS{1'b0}}};
            rem <= '0;
            dvs <= divisor;
            neg <= dividend[FW-1];
        end else if (cnt != '0) begin
            if (!diff[FW]) begin
                rem <= diff;            // Divisor fits
                num <= {num[NW-2:0], 1'b1};
            end else begin
                rem <= rem_sh;          // Restore
                num <= {num[NW-2:0], 1'b0};
            end
        end
    end

    // Sign applied to the magnitude quotient truncates toward zero
    assign quotient = neg ? -num[FW-1:0] : num[FW-1:0];

    a_divisor_positive: assert property (@(posedge clk) disable iff (rst)
        start |-> divisor > 0);

endmodule

// File: hw/chol_dot_reduce.sv
`timescale 1ns/100ps

module chol_dot_reduce (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::idx_t col,
    input  chol_pkg::fix_t a_elem,
    input  chol_pkg::fix_t l_row_k,
    input  chol_pkg::fix_t l_col_k,
    output chol_pkg::idx_t k,
    output logic           done,
    output chol_pkg::fix_t resid
);

    chol_pkg::idx_t  k_q;
    logic            busy;
    chol_pkg::prod_t acc;
    chol_pkg::prod_t acc_base;
    chol_pkg::prod_t prod;

    // First product is taken in the start cycle itself
    assign k        = start ? '0 : k_q;
    assign acc_base = start ? '0 : acc;
    assign prod     = chol_pkg::prod_t'(l_row_k) * chol_pkg::prod_t'(l_col_k);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            k_q  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start || busy) begin
                if (k == col) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    k_q  <= k;   // Left at col so l_col_k reads the pivot
                end else begin
                    busy <= 1'b1;
                    k_q  <= k + chol_pkg::idx_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            if (k == col) begin
                resid <= a_elem - chol_pkg::fix_t'(acc_base[chol_pkg::FRAC_BITS +: 32]);
            end else begin
                acc <= acc_base + prod;
            end
        end
    end

endmodule

// File: hw/chol_matrix_store.sv
`timescale 1ns/100ps

module chol_matrix_store (
    input  logic           clk,
    input  logic           rst,
    input  chol_pkg::mat_t a,
    input  logic           a_valid,
    input  logic           load,
    input  chol_pkg::idx_t row,
    input  chol_pkg::idx_t col,
    input  chol_pkg::idx_t k,
    input  logic           l_we,
    input  chol_pkg::fix_t l_wdata,
    output logic           buf_full,
    output chol_pkg::fix_t a_elem,
    output chol_pkg::fix_t l_row_k,
    output chol_pkg::fix_t l_col_k,
    output chol_pkg::mat_t l
);

    localparam int FW = $bits(chol_pkg::fix_t);
    localparam int MW = $bits(chol_pkg::mat_t);
    localparam chol_pkg::idx_t LAST = chol_pkg::idx_t'(chol_pkg::N_DIM - 1);

    chol_pkg::mat_t in_buf;   // Next matrix waiting on the credit
    chol_pkg::mat_t work_a;
    chol_pkg::mat_t work_l;

    // Element (r,c), r >= c, sits at word r(r+1)/2 + c
    function automatic int pos(input chol_pkg::idx_t r, input chol_pkg::idx_t c);
        return int'(r) * (int'(r) + 1) / 2 + int'(c);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_full <= 1'b0;
        end else if (a_valid) begin
            buf_full <= 1'b1;    // A send in the load cycle refills at once
        end else if (load) begin
            buf_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (a_valid) begin
            in_buf <= a;
        end
        if (load) begin
            work_a <= in_buf;
            work_l <= '0;
        end else if (l_we) begin
            work_l[pos(row, col)*FW +: FW] <= l_wdata;
        end
    end

    // Output copy taken with the last element so l holds during the next matrix
    always_ff @(posedge clk) begin
        if (rst) begin
            l <= '0;
        end else if (l_we && row == LAST && col == LAST) begin
            l <= {l_wdata, work_l[MW-FW-1:0]};
        end
    end

    assign a_elem  = work_a[pos(row, col)*FW +: FW];
    assign l_row_k = work_l[pos(row, k)*FW +: FW];
    assign l_col_k = work_l[pos(col, k)*FW +: FW];  // Pivot l_jj once k reaches col

endmodule

// File: hw/chol_sequencer.sv
`timescale 1ns/100ps

module chol_sequencer (
    input  logic           clk,
    input  logic           rst,
    input  logic           a_valid,
    input  logic           buf_full,
    input  logic           dot_done,
    input  logic           root_done,
    input  logic           div_done,
    output logic           load,
    output logic           credit,
    output chol_pkg::idx_t row,
    output chol_pkg::idx_t col,
    output logic           dot_start,
    output logic           root_start,
    output logic           div_start,
    output logic           l_we,
    output logic           l_valid
);

    localparam chol_pkg::idx_t LAST = chol_pkg::idx_t'(chol_pkg::N_DIM - 1);

    chol_pkg::seq_state_t state;

    // ========================================================================
    // Element walk: column by column, diagonal first, then the rows below
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= chol_pkg::S_IDLE;
            row        <= '0;
            col        <= '0;
            dot_start  <= 1'b0;
            root_start <= 1'b0;
            div_start  <= 1'b0;
        end else begin
            dot_start  <= 1'b0;
            root_start <= 1'b0;
            div_start  <= 1'b0;
            case (state)
                chol_pkg::S_IDLE: begin
                    if (buf_full) begin
                        state <= chol_pkg::S_LOAD;
                    end
                end
                chol_pkg::S_LOAD: begin
                    row       <= '0;
                    col       <= '0;
                    dot_start <= 1'b1;
                    state     <= chol_pkg::S_DOT;
                end
                chol_pkg::S_DOT: begin
                    if (dot_done && row == col) begin
                        root_start <= 1'b1;
                        state      <= chol_pkg::S_ROOT;
                    end else if (dot_done) begin
                        div_start <= 1'b1;
                        state     <= chol_pkg::S_DIV;
                    end
                end
                chol_pkg::S_ROOT: begin
                    if (root_done && col == LAST) begin
                        state <= chol_pkg::S_DONE;
                    end else if (root_done) begin
                        row       <= col + chol_pkg::idx_t'(1);  // First row below the pivot
                        dot_start <= 1'b1;
                        state     <= chol_pkg::S_DOT;
                    end
                end
                chol_pkg::S_DIV: begin
                    if (div_done) begin
                        dot_start <= 1'b1;
                        state     <= chol_pkg::S_DOT;
                        if (row == LAST) begin
                            col <= col + chol_pkg::idx_t'(1);  // Next diagonal
                            row <= col + chol_pkg::idx_t'(1);
                        end else begin
                            row <= row + chol_pkg::idx_t'(1);
                        end
                    end
                end
                chol_pkg::S_DONE: begin
                    state <= buf_full ? chol_pkg::S_LOAD : chol_pkg::S_IDLE;
                end
                default: begin
                    state <= chol_pkg::S_IDLE;
                end
            endcase
        end
    end

    assign load    = (state == chol_pkg::S_LOAD);
    assign credit  = (state == chol_pkg::S_LOAD);   // Buffer free again
    assign l_valid = (state == chol_pkg::S_DONE);
    assign l_we    = (state == chol_pkg::S_ROOT && root_done)
                   || (state == chol_pkg::S_DIV && div_done);

    // Source holds no credit while the buffer is full and not draining
    a_credit_held: assert property (@(posedge clk) disable iff (rst)
        (buf_full && !load) |-> !a_valid);

    // Only one shared unit is ever handed work or finishing
    a_units_exclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({dot_start, root_start, div_start, dot_done, root_done, div_done}));

endmodule

// File: hw/cholesky.sv
`timescale 1ns/100ps

module cholesky #(
    parameter int ROOT_ITERS = 24,
    parameter int DIV_ITERS  = 48
) (
    input  logic           clk,
    input  logic           rst,
    input  chol_pkg::mat_t a,
    input  logic           a_valid,
    output logic           credit,
    output chol_pkg::mat_t l,
    output logic           l_valid
);

    logic           buf_full;
    logic           load;
    chol_pkg::idx_t row;
    chol_pkg::idx_t col;
    chol_pkg::idx_t k;
    logic           dot_start;
    logic           dot_done;
    logic           root_start;
    logic           root_done;
    logic           div_start;
    logic           div_done;
    logic           l_we;
    chol_pkg::fix_t a_elem;
    chol_pkg::fix_t l_row_k;
    chol_pkg::fix_t l_col_k;
    chol_pkg::fix_t resid;
    chol_pkg::fix_t root;
    chol_pkg::fix_t quotient;
    chol_pkg::fix_t l_wdata;

    assign l_wdata = root_done ? root : quotient;  // Diagonal or below

    chol_sequencer u_seq (
        .clk(clk), .rst(rst), .a_valid(a_valid), .buf_full(buf_full),
        .dot_done(dot_done), .root_done(root_done), .div_done(div_done),
        .load(load), .credit(credit), .row(row), .col(col),
        .dot_start(dot_start), .root_start(root_start), .div_start(div_start),
        .l_we(l_we), .l_valid(l_valid)
    );

    chol_matrix_store u_store (
        .clk(clk), .rst(rst), .a(a), .a_valid(a_valid), .load(load),
        .row(row), .col(col), .k(k), .l_we(l_we), .l_wdata(l_wdata),
        .buf_full(buf_full), .a_elem(a_elem), .l_row_k(l_row_k),
        .l_col_k(l_col_k), .l(l)
    );

    chol_dot_reduce u_dot (
        .clk(clk), .rst(rst), .start(dot_start), .col(col), .a_elem(a_elem),
        .l_row_k(l_row_k), .l_col_k(l_col_k), .k(k), .done(dot_done), .resid(resid)
    );

    chol_isqrt #(.ROOT_ITERS(ROOT_ITERS)) u_isqrt (
        .clk(clk), .rst(rst), .start(root_start), .radicand(resid),
        .done(root_done), .root(root)
    );

    // Divisor is l_jj, read through l_col_k while k rests at col
    chol_divider #(.DIV_ITERS(DIV_ITERS)) u_div (
        .clk(clk), .rst(rst), .start(div_start), .dividend(resid),
        .divisor(l_col_k), .done(div_done), .quotient(quotient)
    );

endmodule

// File: include/chol_ref_model.svh
`ifndef CHOL_REF_MODEL_SVH
`define CHOL_REF_MODEL_SVH

// ============================================================================
// Reference arithmetic, same truncations as the RTL
// ============================================================================

function automatic int ref_pos(input int r, input int c);
    return r * (r + 1) / 2 + c;
endfunction

function automatic chol_pkg::fix_t ref_elem(input chol_pkg::mat_t m, input int r, input int c);
    return chol_pkg::fix_t'(m[ref_pos(r, c)*32 +: 32]);
endfunction

// Floor square root of r << 16
function automatic chol_pkg::fix_t ref_isqrt(input chol_pkg::fix_t r);
    longint x;
    longint q;
    longint t;
    x = longint'(r) <<< chol_pkg::FRAC_BITS;
    q = 0;
    for (int b = $bits(chol_pkg::root_t) - 1; b >= 0; b--) begin
        t = q | (longint'(1) << b);
        if (t * t <= x) begin
            q = t;
        end
    end
    return chol_pkg::fix_t'(q);
endfunction

// (r << 16) / d truncated toward zero, low word kept
function automatic chol_pkg::fix_t ref_div(input chol_pkg::fix_t r, input chol_pkg::fix_t d);
    longint n;
    n = longint'(r) <<< chol_pkg::FRAC_BITS;
    return chol_pkg::fix_t'(n / longint'(d));
endfunction

function automatic chol_pkg::mat_t ref_cholesky(input chol_pkg::mat_t a);
    chol_pkg::mat_t  l;
    chol_pkg::prod_t acc;
    chol_pkg::fix_t  r;
    l = '0;
    for (int j = 0; j < chol_pkg::N_DIM; j++) begin
        for (int i = j; i < chol_pkg::N_DIM; i++) begin
            acc = '0;
            for (int k = 0; k < j; k++) begin
                acc += chol_pkg::prod_t'(ref_elem(l, i, k)) * chol_pkg::prod_t'(ref_elem(l, j, k));
            end
            r = ref_elem(a, i, j) - chol_pkg::fix_t'(acc[chol_pkg::FRAC_BITS +: 32]);
            if (i == j) begin
                l[ref_pos(i, j)*32 +: 32] = ref_isqrt(r);
            end else begin
                l[ref_pos(i, j)*32 +: 32] = ref_div(r, ref_elem(l, j, j));
            end
        end
    end
    return l;
endfunction

`endif

// File: tests/cholesky_tb.sv
`timescale 1ns/100ps

module cholesky_tb;

    `include "chol_ref_model.svh"

    localparam int TIMEOUT = 20000;   // Cycles per wait

    logic           clk;
    logic           rst;
    chol_pkg::mat_t a;
    logic           a_valid;
    logic           credit;
    chol_pkg::mat_t l;
    logic           l_valid;

    chol_pkg::mat_t exp_q[$];          // Expected L per matrix sent
    chol_pkg::mat_t exp_cur = '0;      // Expected L of the last l_valid
    chol_pkg::mat_t l_prev  = '0;
    int             n_sent   = 0;
    int             n_credit = 0;
    int             n_done   = 0;

    cholesky #(.ROOT_ITERS(24), .DIV_ITERS(48)) DUT (
        .clk(clk), .rst(rst), .a(a), .a_valid(a_valid),
        .credit(credit), .l(l), .l_valid(l_valid)
    );

    always #50 clk = ~clk;

    // ========================================================================
    // Failure reporting and checks
    // ========================================================================

    task automatic report_mismatch(input string name, input chol_pkg::mat_t exp_v,
                                   input chol_pkg::mat_t got_v);
        $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp_v, got_v);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("%0t %s", $time, what);
        $display("test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            n_sent   <= 0;
            n_credit <= 0;
            n_done   <= 0;
        end else begin
            if (a_valid) n_sent <= n_sent + 1;
            if (credit) n_credit <= n_credit + 1;
            if (l_valid) n_done <= n_done + 1;
            if (l_valid && exp_q.size() > 0) exp_cur <= exp_q.pop_front();
        end
        l_prev <= l;                                        // Previous cycle's output
    end

    a_idle_credit: assert property (@(posedge clk) disable iff (rst)
        n_sent == 0 |-> !credit) else report_mismatch("credit", '0, credit);
    a_idle_valid: assert property (@(posedge clk) disable iff (rst)
        n_sent == 0 |-> !l_valid) else report_mismatch("l_valid", '0, l_valid);
    a_idle_l: assert property (@(posedge clk) disable iff (rst)
        n_sent == 0 |-> l == '0) else report_mismatch("l", '0, l);
    a_credit_pulse: assert property (@(posedge clk) disable iff (rst)
        credit |=> !credit) else report_error("credit stayed high for more than one cycle");
    a_credit_count: assert property (@(posedge clk) disable iff (rst)
        credit |-> n_credit < n_sent) else report_error("credit returned with no matrix taken");
    a_credit_first: assert property (@(posedge clk) disable iff (rst)
        l_valid |-> n_credit > n_done) else report_error("l_valid came before its credit");
    a_result_pending: assert property (@(posedge clk) disable iff (rst)
        l_valid |-> n_done < n_sent) else report_error("l_valid with no matrix outstanding");
    a_result_value: assert property (@(posedge clk) disable iff (rst)
        l_valid |=> l == exp_cur) else report_mismatch("l", exp_cur, l);
    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        !l_valid |-> l == l_prev) else report_mismatch("l", l_prev, l);

    // ========================================================================
    // Stimulus
    // ========================================================================

    // A = L * L^T, lower triangle, bits 47:16 of each sum
    function automatic chol_pkg::mat_t product_llt(input chol_pkg::mat_t lm);
        chol_pkg::mat_t  am;
        chol_pkg::prod_t acc;
        am = '0;
        for (int i = 0; i < chol_pkg::N_DIM; i++) begin
            for (int j = 0; j <= i; j++) begin
                acc = '0;
                for (int k = 0; k <= j; k++) begin
                    acc += chol_pkg::prod_t'(ref_elem(lm, i, k))
                         * chol_pkg::prod_t'(ref_elem(lm, j, k));
                end
                am[ref_pos(i, j)*32 +: 32] = acc[chol_pkg::FRAC_BITS +: 32];
            end
        end
        return am;
    endfunction

    function automatic chol_pkg::mat_t integer_lower();
        int             vals [chol_pkg::N_ELEM] = '{2, 1, 3, -1, 2, 4, 0, 1, -2, 1,
                                                    3, -1, 1, 2, 5};
        chol_pkg::mat_t lm;
        lm = '0;
        for (int p = 0; p < chol_pkg::N_ELEM; p++) begin
            lm[p*32 +: 32] = vals[p] * 65536;
        end
        return lm;
    endfunction

    // Diagonal in [1, 3), the rest in [-1, 1)
    function automatic chol_pkg::mat_t random_lower();
        chol_pkg::mat_t lm;
        lm = '0;
        for (int i = 0; i < chol_pkg::N_DIM; i++) begin
            for (int j = 0; j <= i; j++) begin
                if (i == j) begin
                    lm[ref_pos(i, j)*32 +: 32] = 32'h0001_0000 + ($urandom % 32'h0002_0000);
                end else begin
                    lm[ref_pos(i, j)*32 +: 32] = ($urandom % 32'h0002_0000) - 32'h0001_0000;
                end
            end
        end
        return lm;
    endfunction

    task automatic wait_for_credit();
        int cycles;
        cycles = 0;
        while (1 + n_credit - n_sent <= 0) begin
            if (cycles == TIMEOUT) report_error("timed out waiting for a credit");
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_for_results(input int count);
        int cycles;
        cycles = 0;
        while (n_done < count) begin
            if (cycles == TIMEOUT) report_error("timed out waiting for l_valid");
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic send_matrix(input chol_pkg::mat_t am, input chol_pkg::mat_t expected);
        wait_for_credit();
        a       = am;
        a_valid = 1'b1;
        exp_q.push_back(expected);
        @(negedge clk);
        a_valid = 1'b0;
    endtask

    initial begin
        chol_pkg::mat_t lm;
        chol_pkg::mat_t am;
        void'($urandom(32'hc04d_82b3));
        clk     = 1'b0;
        rst     = 1'b1;
        a       = '0;
        a_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);                          // Idle outputs before any send

        lm = integer_lower();
        send_matrix(product_llt(lm), lm);                   // Exact integer factor
        repeat (2) begin
            lm = random_lower();
            am = product_llt(lm);
            send_matrix(am, ref_cholesky(am));              // Sent on each returned credit
        end
        wait_for_results(3);
        repeat (2) @(negedge clk);

        if (n_credit != n_sent) begin
            $display("Credit count %0d does not match %0d matrices sent", n_credit, n_sent);
            $display("test failed");
            $fatal(1);
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+include
hw/chol_pkg.sv
hw/chol_isqrt.sv
hw/chol_divider.sv
hw/chol_dot_reduce.sv
hw/chol_matrix_store.sv
hw/chol_sequencer.sv
hw/cholesky.sv
tests/cholesky_tb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and decide pass or fail from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module cholesky_tb -f build.f \
    -o cholesky_sim > sim.log 2>&1 \
    && ./obj_dir/cholesky_sim >> sim.log 2>&1
grep -q "test passed" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
